// ==== sim.f ====
verilog/screen_pkg.sv
verilog/char_gen.sv
verilog/fill_buf.sv
verilog/screen_ram.sv
verilog/text_screen.sv
sim/tb_text_screen.sv

// ==== sim/tb_text_screen.sv ====
// self-checking testbench for the text screen, runs a table of fill and readback steps.
`default_nettype none
`timescale 1ns/1ps

module tb_text_screen
    import screen_pkg::*;
;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // geometry and step table
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int width = screen_width;
    localparam int height = screen_height;
    localparam int cells = width * height;
    localparam int xw = addr_bits(width);
    localparam int yw = addr_bits(height);

    // operations.
    localparam int op_boot = 0;
    localparam int op_random = 1;
    localparam int op_blank = 2;
    localparam int op_abort = 3;
    localparam int op_latency = 4;

    // expected result classes.
    localparam int exp_alnum = 0;
    localparam int exp_blank = 1;
    localparam int exp_changed = 2;
    localparam int exp_match = 3;

    localparam int num_steps = 8;
    localparam int step_op [num_steps] = '{
        op_boot, op_latency, op_blank, op_random,
        op_abort, op_latency, op_blank, op_random
    };
    localparam int step_exp [num_steps] = '{
        exp_alnum, exp_match, exp_blank, exp_changed,
        exp_alnum, exp_match, exp_blank, exp_changed
    };

    // each step needs at most a fill plus a readback, with some slack.
    localparam int timeout_limit = num_steps * (2 * cells + 20);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // signals
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic                  clk;
    logic                  reset;
    logic                  refresh;
    logic                  zero_buf;
    logic                  busy;
    logic [xw-1:0]         rd_x;
    logic [yw-1:0]         rd_y;
    logic [char_width-1:0] rd_char;

    // last full readback, and the last one taken after a random fill.
    logic [char_width-1:0] grid [cells];
    logic [char_width-1:0] rand_snap [cells];
    // codes a random fill may produce, indexed by code.
    logic                  valid_code [256];

    int unsigned lcg_state;
    int          cycles = 0;

    text_screen #(
        .width      (width),
        .height     (height),
        .char_width (char_width),
        .blank_char (blank_char)
    ) u_dut (
        .clk      (clk),
        .reset    (reset),
        .refresh  (refresh),
        .zero_buf (zero_buf),
        .busy     (busy),
        .rd_x     (rd_x),
        .rd_y     (rd_y),
        .rd_char  (rd_char)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // run limit.
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_limit) begin
            $display("timeout: run went past %0d cycles without finishing", timeout_limit);
            $display("*** TEST FAILED ***");
            $fatal(1, "simulation stopped");
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // reference character mapping, digits then upper then lower case.
    function automatic logic [7:0] ref_char(input int index);
        string charset;
        charset = "0123456789ABCDEFGHIJKLMNOPQRSTUVWXYZabcdefghijklmnopqrstuvwxyz";
        return charset[index];
    endfunction

    // linear congruential generator, upper bits are the better ones.
    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return (lcg_state >> 16) & 32'h7fff;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "simulation stopped");
        end
    endtask

    // one cycle refresh pulse with the requested mode.
    task automatic start_fill(input logic blank);
        refresh  = 1'b1;
        zero_buf = blank;
        @(negedge clk);
        refresh  = 1'b0;
        zero_buf = 1'b0;
    endtask

    // count busy cycles until the fill ends.
    task automatic wait_fill(output int count);
        count = 0;
        while (busy && count <= cells + 2) begin
            count++;
            @(negedge clk);
        end
        check("busy", busy, 1'b0);
    endtask

    // pipelined readback, address k goes out while data k-1 comes back.
    task automatic read_grid();
        for (int k = 0; k <= cells; k++) begin
            if (k > 0) begin
                grid[k - 1] = rd_char;
            end
            if (k < cells) begin
                rd_x = xw'(k % width);
                rd_y = yw'(k / width);
            end
            @(negedge clk);
        end
    endtask

    // random single reads against the last readback.
    task automatic check_latency();
        int a;
        for (int i = 0; i < 16; i++) begin
            a = lcg_next() % cells;
            rd_x = xw'(a % width);
            rd_y = yw'(a / width);
            @(negedge clk);
            check($sformatf("rd_char[%0d]", a), rd_char, grid[a]);
        end
    endtask

    // compare the readback with the expected class of the step.
    task automatic verify_grid(input int exp);
        int diff;
        diff = 0;
        for (int k = 0; k < cells; k++) begin
            if (exp == exp_blank) begin
                check($sformatf("rd_char[%0d]", k), grid[k], blank_char);
            end else if (exp == exp_alnum || exp == exp_changed) begin
                // blank is not a valid code, so this also rules out blanks.
                check($sformatf("valid_code(rd_char[%0d])", k), valid_code[grid[k]], 1'b1);
            end
            if (grid[k] != rand_snap[k]) begin
                diff++;
            end
        end
        if (exp == exp_changed) begin
            check("cells_changed", diff > 0, 1'b1);
        end
        if (exp == exp_alnum || exp == exp_changed) begin
            rand_snap = grid;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        int count;
        int abort_at;
        reset     = 1'b1;
        refresh   = 1'b0;
        zero_buf  = 1'b0;
        rd_x      = '0;
        rd_y      = '0;
        lcg_state = 57;
        for (int i = 0; i < 256; i++) begin
            valid_code[i] = 1'b0;
        end
        for (int i = 0; i < num_chars; i++) begin
            valid_code[ref_char(i)] = 1'b1;
        end
        for (int k = 0; k < cells; k++) begin
            rand_snap[k] = blank_char;
        end

        repeat (10) @(negedge clk);
        reset = 1'b0;
        // reset itself starts a random fill.
        check("busy", busy, 1'b1);

        for (int s = 0; s < num_steps; s++) begin
            case (step_op[s])
                op_boot: begin
                    wait_fill(count);
                    check("boot_busy_in_limit", count <= cells + 2, 1'b1);
                    read_grid();
                end
                op_random, op_blank: begin
                    start_fill(step_op[s] == op_blank);
                    wait_fill(count);
                    check("busy_cycles", count, cells);
                    read_grid();
                end
                op_abort: begin
                    // blank fill cut short by a random refresh.
                    start_fill(1'b1);
                    abort_at = 1 + lcg_next() % (cells - 2);
                    repeat (abort_at) @(negedge clk);
                    check("busy", busy, 1'b1);
                    start_fill(1'b0);
                    wait_fill(count);
                    check("busy_cycles", count, cells);
                    read_grid();
                end
                default: begin
                    check_latency();
                end
            endcase
            verify_grid(step_exp[s]);
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/char_gen.sv ====
// pseudo-random character index source, feeds one index per clock to the fill raster.
`default_nettype none
`timescale 1ns/1ps

module char_gen
    import screen_pkg::*;
#(
    // start state of the shift register, nonzero.
    parameter logic [15:0] lfsr_seed = lfsr_reset_value
) (
    input  logic       clk,
    input  logic       reset,
    output logic [5:0] index
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // shift register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // current lfsr state.
    logic [15:0] lfsr_q;
    // feedback bit shifted in at the bottom.
    logic        feedback;
    // unfolded low six bits of the state.
    logic [5:0]  raw;

    // taps 16, 14, 13, 11 give a maximal length sequence.
    // bit numbering here is zero based, so tap n is bit n-1.
    assign feedback = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];

    // fibonacci form, shifts toward the msb every cycle.
    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr_q <= lfsr_seed;
        end else begin
            lfsr_q <= {lfsr_q[14:0], feedback};
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // index folding
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // six bits reach 63, two past the table.
    assign raw = lfsr_q[5:0];

    // 62 and 63 wrap onto 0 and 1.
    // this gives the first two digits a slight bias, which is acceptable.
    always_comb begin
        if (raw >= 6'(num_chars)) begin
            index = raw - 6'(num_chars);
        end else begin
            index = raw;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the all-zero state is a lock-up state of the lfsr.
    // once out of reset the state must never reach it, and the
    // index handed to the fill must stay inside the table.
    a_lfsr_alive: assert property (
        @(posedge clk) disable iff (reset)
        !$past(reset) |-> (lfsr_q != 16'h0) && (index < 6'(num_chars))
    ) else $error("char_gen: lfsr locked or index out of range");

endmodule

`default_nettype wire

// ==== verilog/fill_buf.sv ====
// raster fill engine, sweeps the grid one cell per clock with random or blank characters.
`default_nettype none
`timescale 1ns/1ps

module fill_buf
    import screen_pkg::*;
#(
    parameter int width = screen_width,
    parameter int height = screen_height,
    parameter int char_width = screen_pkg::char_width,
    parameter logic [char_width-1:0] blank_char = screen_pkg::blank_char
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             refresh,
    input  logic                             zero_buf,
    output logic                             write_en,
    output logic [addr_bits(width)-1:0]      x,
    output logic [addr_bits(height)-1:0]     y,
    output logic [char_width-1:0]            c_out
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // local constants
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int xw = addr_bits(width);
    localparam int yw = addr_bits(height);

    // cursor position of the final cell in a row and in the grid.
    localparam logic [xw-1:0] last_x = xw'(width - 1);
    localparam logic [yw-1:0] last_y = yw'(height - 1);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // signals
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // random index from the character source.
    logic [5:0] index;
    // blank request latched at the start of a fill.
    logic       zero_q;
    // any event that restarts the sweep at cell 0.
    logic       start;
    // cursor sits on the end of a row.
    logic       row_end;
    // cursor sits on the final cell of the grid.
    logic       last_cell;

    assign start     = reset | refresh;
    assign row_end   = (x == last_x);
    assign last_cell = row_end && (y == last_y);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // raster cursor and write strobe
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // a start loads cell (0,0) and raises the strobe.
    // while the strobe is up, x steps every cycle and y steps on a
    // row wrap. the row counter wraps on the height.
    always_ff @(posedge clk) begin
        if (start) begin
            x        <= '0;
            y        <= '0;
            write_en <= 1'b1;
        end else if (write_en) begin
            if (row_end) begin
                x <= '0;
                if (y == last_y) begin
                    y <= '0;
                end else begin
                    y <= y + 1'b1;
                end
            end else begin
                x <= x + 1'b1;
            end
            // strobe drops once the final cell has gone out.
            if (last_cell) begin
                write_en <= 1'b0;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fill mode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // zero_buf is sampled with the refresh and held for the sweep.
    // the fill started by reset is always a random one.
    always_ff @(posedge clk) begin
        if (reset) begin
            zero_q <= 1'b0;
        end else if (refresh) begin
            zero_q <= zero_buf;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // character output
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // blank fill substitutes the fixed code.
    // otherwise the live index is mapped to ascii.
    always_comb begin
        if (zero_q) begin
            c_out = blank_char;
        end else begin
            c_out = char_width'(index_to_char(index));
        end
    end

    // the source runs free, so each cell gets whatever index is current.
    char_gen #(
        .lfsr_seed (lfsr_reset_value)
    ) u_char_gen (
        .clk   (clk),
        .reset (reset),
        .index (index)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the cursor must stay on the grid at all times.
    // compared as integers, a power of two size does not fit the cursor width.
    a_cursor_range: assert property (
        @(posedge clk) disable iff (reset)
        (int'(x) < width) && (int'(y) < height)
    ) else $error("fill_buf: cursor left the grid");

    // after the final cell the strobe must be low next cycle,
    // unless a refresh restarted the sweep on that same edge.
    a_fill_ends: assert property (
        @(posedge clk) disable iff (reset)
        (write_en && last_cell) |=> (!write_en || $past(refresh))
    ) else $error("fill_buf: write strobe held past the last cell");

endmodule

`default_nettype wire

// ==== verilog/screen_pkg.sv ====
// shared grid dimensions, character constants and helper functions for the text screen.
`default_nettype none

package screen_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // grid geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // default column count of the grid.
    localparam int screen_width = 16;
    // default row count of the grid.
    localparam int screen_height = 8;
    // bits per stored character code.
    localparam int char_width = 8;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // character set
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // code written by a blank fill (ascii space).
    localparam logic [7:0] blank_char = 8'h20;

    // 10 digits, then 26 upper case, then 26 lower case.
    localparam int num_chars = 62;
    localparam int upper_base = 10;
    localparam int lower_base = 36;

    // ascii codes of the first symbol in each range.
    localparam int digit_code = 8'h30;
    localparam int upper_code = 8'h41;
    localparam int lower_code = 8'h61;

    // random source start value, must not be zero.
    localparam logic [15:0] lfsr_reset_value = 16'hACE1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // functions
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // address width for n entries.
    // never below one bit, so a 1-wide grid still gets a real port.
    function automatic int addr_bits(input int n);
        int bits;
        bits = (n > 1) ? $clog2(n) : 1;
        return bits;
    endfunction

    // map a character index 0..61 onto its ascii code.
    // indices past the table fall into the lower case range.
    function automatic logic [7:0] index_to_char(input logic [5:0] index);
        int unsigned i;
        logic [7:0] code;
        i = index;
        if (i >= lower_base) begin
            code = 8'(i - lower_base + lower_code);
        end else if (i >= upper_base) begin
            code = 8'(i - upper_base + upper_code);
        end else begin
            code = 8'(i + digit_code);
        end
        return code;
    endfunction

endpackage

`default_nettype wire

// ==== verilog/screen_ram.sv ====
// character cell memory, fill engine writes on one port while the host reads on the other.
`default_nettype none
`timescale 1ns/1ps

module screen_ram
    import screen_pkg::*;
#(
    parameter int width = screen_width,
    parameter int height = screen_height,
    parameter int char_width = screen_pkg::char_width
) (
    input  logic                            clk,
    input  logic                            write_en,
    input  logic [addr_bits(width)-1:0]     wr_x,
    input  logic [addr_bits(height)-1:0]    wr_y,
    input  logic [char_width-1:0]           wr_char,
    input  logic [addr_bits(width)-1:0]     rd_x,
    input  logic [addr_bits(height)-1:0]    rd_y,
    output logic [char_width-1:0]           rd_char
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int depth = width * height;
    localparam int aw = addr_bits(depth);

    // one entry per cell, row major.
    logic [char_width-1:0] mem [depth];

    // flat addresses of the two ports.
    logic [aw-1:0] wr_addr;
    logic [aw-1:0] rd_addr;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address mapping
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // row times width plus column.
    // operands widened first so the product does not truncate.
    assign wr_addr = aw'(wr_y) * aw'(width) + aw'(wr_x);
    assign rd_addr = aw'(rd_y) * aw'(width) + aw'(rd_x);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // cell updates on the edge that sees the strobe.
    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[wr_addr] <= wr_char;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // data appears one cycle after the address.
    // a read that hits the cell being written returns the old code.
    always_ff @(posedge clk) begin
        rd_char <= mem[rd_addr];
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the fill engine must never aim a write outside the grid.
    a_write_range: assert property (
        @(posedge clk)
        write_en |-> (int'(wr_x) < width) && (int'(wr_y) < height)
    ) else $error("screen_ram: write address off the grid");

endmodule

`default_nettype wire

// ==== verilog/text_screen.sv ====
// top level of the text screen buffer, joins the fill engine to the cell memory.
`default_nettype none
`timescale 1ns/1ps

module text_screen
    import screen_pkg::*;
#(
    parameter int width = screen_width,
    parameter int height = screen_height,
    parameter int char_width = screen_pkg::char_width,
    parameter logic [char_width-1:0] blank_char = screen_pkg::blank_char
) (
    input  logic                            clk,
    input  logic                            reset,
    // one cycle pulse, starts or restarts a fill.
    input  logic                            refresh,
    // sampled with refresh, high asks for a blank fill.
    input  logic                            zero_buf,
    // high while a fill is writing cells.
    output logic                            busy,
    // host read address.
    input  logic [addr_bits(width)-1:0]     rd_x,
    input  logic [addr_bits(height)-1:0]    rd_y,
    // cell code, one cycle after rd_x and rd_y.
    output logic [char_width-1:0]           rd_char
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fill to memory write path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic                          wr_en;
    logic [addr_bits(width)-1:0]   wr_x;
    logic [addr_bits(height)-1:0]  wr_y;
    logic [char_width-1:0]         wr_char;

    // the write strobe is exactly the busy window.
    assign busy = wr_en;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instances
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // raster sweep, one cell per clock.
    fill_buf #(
        .width      (width),
        .height     (height),
        .char_width (char_width),
        .blank_char (blank_char)
    ) u_fill_buf (
        .clk      (clk),
        .reset    (reset),
        .refresh  (refresh),
        .zero_buf (zero_buf),
        .write_en (wr_en),
        .x        (wr_x),
        .y        (wr_y),
        .c_out    (wr_char)
    );

    // cell store, host reads run alongside the fill
    screen_ram #(
        .width      (width),
        .height     (height),
        .char_width (char_width)
    ) u_screen_ram (
        .clk      (clk),
        .write_en (wr_en),
        .wr_x     (wr_x),
        .wr_y     (wr_y),
        .wr_char  (wr_char),
        .rd_x     (rd_x),
        .rd_y     (rd_y),
        .rd_char  (rd_char)
    );

endmodule

`default_nettype wire
